// ==== build.f ====
logic/pibus_pkg.sv
logic/xfer_queue.sv
logic/pibus_master.sv
logic/pibus_arbiter.sv
logic/pibus_mem_slave.sv
logic/pibus_subsys.sv
testbench/tb_pibus.sv

// ==== logic/pibus_arbiter.sv ====
/* single-master bus arbiter with data-phase stall timeout */
`timescale 1ns/100ps

module pibus_arbiter (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            REQ,
   input  logic            bus_active,
   input  pibus_pkg::ack_e ACK,
   output logic            GNT,
   output logic            TOUT
);
   import pibus_pkg::*;

   logic [$clog2(timeout_cycles)-1:0] stall_cnt;
   logic                              stalled;

   // no final acknowledge yet
   assign stalled = bus_active && ((ACK == ACK_WAT) || (ACK == ACK_IDLE));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         GNT <= 1'b0;
      else
         GNT <= REQ || (GNT && bus_active); // kept through the open data phase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         stall_cnt <= '0;
         TOUT      <= 1'b0;
      end
      else if (!stalled)
      begin
         stall_cnt <= '0;
         TOUT      <= 1'b0;
      end
      else if (int'(stall_cnt) == timeout_cycles - 1)
      begin
         stall_cnt <= '0;
         TOUT      <= 1'b1; // single pulse for the master abort
      end
      else
      begin
         stall_cnt <= stall_cnt + 1'b1;
         TOUT      <= 1'b0;
      end
   end

endmodule

// ==== logic/pibus_master.sv ====
/* PI-bus master: runs queued commands through request, address and data
   phases with locked overlap, retract replay and abort on ERR or timeout */
`timescale 1ns/100ps

module pibus_master (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         cmd_pending,
   input  pibus_pkg::xfer_cmd_t         head,
   output logic                         cmd_take,
   output logic                         REQ,
   input  logic                         GNT,
   input  logic                         TOUT,
   input  pibus_pkg::ack_e              ACK,
   input  logic [pibus_pkg::data_w-1:0] DIN,
   output pibus_pkg::bus_addr_t         bus,
   output logic [pibus_pkg::data_w-1:0] DOUT,
   output logic                         phase_valid,
   output logic                         bus_active,
   output logic                         result_valid,
   output pibus_pkg::xfer_result_t      result
);
   import pibus_pkg::*;

   mst_state_e state;
   xfer_cmd_t  held;    // in-flight command for replay
   xfer_cmd_t  ph_cmd;
   logic       replay;
   logic       in_data;
   logic       abort;

   assign in_data    = (state == MST_DATA) || (state == MST_ADDR_DATA);
   assign bus_active = in_data;
   assign abort      = in_data && ((ACK == ACK_ERR) || TOUT);
   assign ph_cmd     = replay ? held : head;

   // overlapped take only once the current data phase completes
   assign cmd_take = ((state == MST_ADDR) && !replay) ||
                     ((state == MST_ADDR_DATA) && cmd_pending && (ACK == ACK_RDY) && !TOUT);
   assign phase_valid = (state == MST_ADDR) || cmd_take;

   // early request while the last data phase drains
   assign REQ = (state == MST_REQ) || ((state == MST_DATA) && cmd_pending);

   assign DOUT = {2{held.addr[15:0]}}; // write pattern

   always_comb
   begin
      bus = '0;
      if (phase_valid)
      begin
         bus.addr = ph_cmd.addr;
         bus.opc  = ph_cmd.size;
         bus.read = ph_cmd.read;
         bus.lock = ph_cmd.lock;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state        <= MST_IDLE;
         replay       <= 1'b0;
         result_valid <= 1'b0;
      end
      else
      begin
         result_valid <= 1'b0;
         case (state)
            MST_IDLE:
               if (cmd_pending)
                  state <= MST_REQ;
            MST_REQ:
               if (GNT)
                  state <= MST_ADDR;
            MST_ADDR:
            begin
               replay <= 1'b0;
               state  <= ph_cmd.lock ? MST_ADDR_DATA : MST_DATA;
            end
            MST_DATA, MST_ADDR_DATA:
            begin
               if (abort)
               begin
                  result_valid <= 1'b1;
                  state        <= MST_IDLE;
               end
               else if (ACK == ACK_RTR)
               begin
                  replay <= 1'b1; // same command again
                  state  <= MST_RTRCT;
               end
               else if (ACK == ACK_RDY)
               begin
                  result_valid <= 1'b1;
                  if (cmd_take)
                     state <= head.lock ? MST_ADDR_DATA : MST_DATA;
                  else if (cmd_pending)
                     state <= MST_REQ;
                  else
                     state <= MST_IDLE;
               end
            end
            MST_RTRCT:
               if (!GNT)
                  state <= MST_REQ; // arbitrate again once the bus is released
            default:
               state <= MST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmd_take)
         held <= head;
      if (abort)
         result <= '{status: STAT_ABORT, rdata: '0};
      else if (in_data && (ACK == ACK_RDY))
         result <= '{status: STAT_OK, rdata: (held.read ? DIN : '0)};
   end

   // address phase only under grant
   a_addr_granted: assert property (@(posedge clk) disable iff (!rst_n)
      (state == MST_ADDR) |-> GNT);

endmodule

// ==== logic/pibus_mem_slave.sv ====
/* PI-bus memory slave; the address region picks ready, wait, retract,
   error or hang behaviour */
`timescale 1ns/100ps

module pibus_mem_slave (
   input  logic                         clk,
   input  logic                         rst_n,
   input  pibus_pkg::bus_addr_t         bus,
   input  logic [pibus_pkg::data_w-1:0] DOUT,
   input  logic                         phase_valid,
   output pibus_pkg::ack_e              ACK,
   output logic [pibus_pkg::data_w-1:0] DIN
);
   import pibus_pkg::*;

   logic [data_w-1:0]            mem [mem_words];
   logic [$clog2(mem_words)-1:0] idx;
   logic [addr_w-1:0]            ph_addr;
   region_e                      ph_region;
   logic                         ph_read;
   logic                         ph_half;
   logic                         ph_live;   // phase awaiting its final ack
   logic                         wait_done;
   logic                         rtr_flag;  // first attempt already retracted

   assign idx = ph_addr[$clog2(mem_words)-1:0];
   assign DIN = mem[idx];

   always_comb
   begin
      ACK = ACK_IDLE;
      if (ph_live)
      begin
         case (ph_region)
            REG_FAST:    ACK = ACK_RDY;
            REG_WAIT:    ACK = wait_done ? ACK_RDY : ACK_WAT;
            REG_RETRACT: ACK = rtr_flag ? ACK_RDY : ACK_RTR;
            REG_FAULT:   ACK = ph_addr[27] ? ACK_WAT : ACK_ERR; // bit 27 set hangs
            default:     ACK = ACK_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ph_live   <= 1'b0;
         wait_done <= 1'b0;
         rtr_flag  <= 1'b0;
      end
      else
      begin
         if (phase_valid)
         begin
            ph_live   <= 1'b1;
            wait_done <= 1'b0;
         end
         else if ((ACK == ACK_RDY) || (ACK == ACK_ERR) || (ACK == ACK_RTR))
            ph_live <= 1'b0;
         else if (ACK == ACK_WAT)
            wait_done <= 1'b1;

         if (ACK == ACK_RTR)
            rtr_flag <= 1'b1;
         else if ((ACK == ACK_RDY) && (ph_region == REG_RETRACT))
            rtr_flag <= 1'b0; // replay went through
      end
   end

   always_ff @(posedge clk)
   begin
      if (phase_valid)
      begin
         ph_addr   <= bus.addr;
         ph_region <= region_e'(bus.addr[addr_w-1 -: 2]);
         ph_read   <= bus.read;
         ph_half   <= (bus.opc == OPC_HALF);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         mem <= '{default: '0};
      else if ((ACK == ACK_RDY) && !ph_read)
      begin
         if (ph_half)
            mem[idx][15:0] <= DOUT[15:0];
         else
            mem[idx] <= DOUT;
      end
   end

   // a new address phase only lands on a finishing or abandoned hung phase
   a_phase_overlap: assert property (@(posedge clk) disable iff (!rst_n)
      (phase_valid && ph_live) |-> ((ACK == ACK_RDY) || (ph_region == REG_FAULT)));

endmodule

// ==== logic/pibus_pkg.sv ====
/* PI-bus shared definitions: bus widths, acknowledge, opcode and state
   encodings, plus the host command and result records */
package pibus_pkg;

   localparam int addr_w         = 30; // word address
   localparam int data_w         = 32;
   localparam int queue_depth    = 4;
   localparam int timeout_cycles = 16; // stalled data cycles before TOUT
   localparam int mem_words      = 64;

   // ERR and RTR have distinct codes
   typedef enum logic [2:0] {
      ACK_IDLE = 3'b000,
      ACK_RDY  = 3'b001,
      ACK_WAT  = 3'b010,
      ACK_RTR  = 3'b011,
      ACK_ERR  = 3'b100
   } ack_e;

   typedef enum logic [3:0] {
      OPC_WORD = 4'b0000,
      OPC_HALF = 4'b0001
   } opc_e;

   typedef enum logic [2:0] {
      MST_IDLE,
      MST_REQ,
      MST_ADDR,
      MST_ADDR_DATA,
      MST_DATA,
      MST_RTRCT
   } mst_state_e;

   // top two address bits
   typedef enum logic [1:0] {
      REG_FAST    = 2'b00,
      REG_WAIT    = 2'b01,
      REG_RETRACT = 2'b10,
      REG_FAULT   = 2'b11
   } region_e;

   typedef enum logic {
      STAT_OK    = 1'b0,
      STAT_ABORT = 1'b1
   } stat_e;

   typedef struct packed {
      logic              read;
      logic              lock;
      opc_e              size;
      logic [addr_w-1:0] addr;
   } xfer_cmd_t;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      opc_e              opc;
      logic              read;
      logic              lock;
   } bus_addr_t;

   typedef struct packed {
      stat_e             status;
      logic [data_w-1:0] rdata;
   } xfer_result_t;

endpackage

// ==== logic/pibus_subsys.sv ====
/* PI-bus subsystem: command queue, master, arbiter and memory slave */
`timescale 1ns/100ps

module pibus_subsys (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    cmd_push,
   input  pibus_pkg::xfer_cmd_t    cmd,
   output logic                    cmd_full,
   output logic                    result_valid,
   output pibus_pkg::xfer_result_t result
);
   import pibus_pkg::*;

   xfer_cmd_t         head;
   logic              cmd_pending;
   logic              cmd_take;
   logic              REQ;
   logic              GNT;
   logic              TOUT;
   logic              bus_active;
   logic              phase_valid;
   ack_e              ACK;
   bus_addr_t         bus;
   logic [data_w-1:0] DIN;
   logic [data_w-1:0] DOUT;

   xfer_queue u_queue (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_push    (cmd_push),
      .cmd         (cmd),
      .cmd_take    (cmd_take),
      .cmd_full    (cmd_full),
      .cmd_pending (cmd_pending),
      .head        (head)
   );

   pibus_master u_master (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_pending  (cmd_pending),
      .head         (head),
      .cmd_take     (cmd_take),
      .REQ          (REQ),
      .GNT          (GNT),
      .TOUT         (TOUT),
      .ACK          (ACK),
      .DIN          (DIN),
      .bus          (bus),
      .DOUT         (DOUT),
      .phase_valid  (phase_valid),
      .bus_active   (bus_active),
      .result_valid (result_valid),
      .result       (result)
   );

   pibus_arbiter u_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .REQ        (REQ),
      .bus_active (bus_active),
      .ACK        (ACK),
      .GNT        (GNT),
      .TOUT       (TOUT)
   );

   pibus_mem_slave u_slave (
      .clk         (clk),
      .rst_n       (rst_n),
      .bus         (bus),
      .DOUT        (DOUT),
      .phase_valid (phase_valid),
      .ACK         (ACK),
      .DIN         (DIN)
   );

endmodule

// ==== logic/xfer_queue.sv ====
/* command FIFO between the host strobe and the bus master */
`timescale 1ns/100ps

module xfer_queue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_push,
   input  pibus_pkg::xfer_cmd_t cmd,
   input  logic                 cmd_take,
   output logic                 cmd_full,
   output logic                 cmd_pending,
   output pibus_pkg::xfer_cmd_t head
);
   import pibus_pkg::*;

   xfer_cmd_t                        slots [queue_depth];
   logic [$clog2(queue_depth)-1:0]   wr_ptr;
   logic [$clog2(queue_depth)-1:0]   rd_ptr;
   logic [$clog2(queue_depth+1)-1:0] count;

   assign cmd_full    = (count == queue_depth);
   assign cmd_pending = (count != 0);
   assign head        = slots[rd_ptr];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (cmd_push)
            wr_ptr <= wr_ptr + 1'b1; // wraps at the power-of-two depth
         if (cmd_take)
            rd_ptr <= rd_ptr + 1'b1;
         case ({cmd_push, cmd_take})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmd_push)
         slots[wr_ptr] <= cmd;
   end

   // host and master both respect the levels
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_push |-> !cmd_full);
   a_no_take_empty: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_take |-> cmd_pending);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the PI-bus testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_pibus -f build.f &&
sim_out=$(./obj_dir/Vtb_pibus 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Verification passed" &&
echo "simulation run: pass" ||
{ echo "simulation run: fail"; exit 1; }

// ==== testbench/tb_pibus.sv ====
/* PI-bus subsystem testbench: directed tests checked against a reference
   memory model, with one result expected per pushed command */
`timescale 1ns/100ps

module tb_pibus;
   import pibus_pkg::*;

   localparam int clk_period  = 20;
   localparam int n_tests     = 5;
   localparam int result_wait = 200; // cycles per batch with room for a timeout
   localparam int settle      = 8;

   logic              clk;
   logic              rst_n;
   logic              cmd_push;
   xfer_cmd_t         cmd;
   logic              cmd_full;
   logic              result_valid;
   xfer_result_t      result;

   logic [data_w-1:0] model_mem [mem_words];
   xfer_result_t      exp_q [$];
   xfer_result_t      got_q [$];
   integer            seed;
   int                err_cnt;
   int                fail_tests;
   int                full_waits;

   pibus_subsys dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_push     (cmd_push),
      .cmd          (cmd),
      .cmd_full     (cmd_full),
      .result_valid (result_valid),
      .result       (result)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial
   begin
      #(n_tests * 400 * clk_period);
      $display("%0t: watchdog expired before the tests finished", $time);
      $display("Verification failed");
      $finish;
   end

   // collect results mid-cycle
   always @(negedge clk)
   begin
      if (rst_n && result_valid)
         got_q.push_back(result);
   end

   function automatic xfer_result_t model_xfer(input xfer_cmd_t c);
      xfer_result_t                 r;
      logic [$clog2(mem_words)-1:0] i;
      r.status = STAT_OK;
      r.rdata  = '0;
      i        = c.addr[$clog2(mem_words)-1:0];
      if (c.addr[addr_w-1 -: 2] == REG_FAULT)
         r.status = STAT_ABORT; // error and hang both leave memory alone
      else if (c.read)
         r.rdata = model_mem[i];
      else if (c.size == OPC_HALF)
         model_mem[i][15:0] = c.addr[15:0];
      else
         model_mem[i] = {c.addr[15:0], c.addr[15:0]};
      return r;
   endfunction

   function automatic logic [addr_w-1:0] rand_addr(input region_e r);
      logic [addr_w-1:0] a;
      a = addr_w'($random(seed));
      a[addr_w-1 -: 2] = r;
      return a;
   endfunction

   function automatic xfer_cmd_t mk_cmd(input logic rd, input logic lk, input opc_e sz,
                                        input logic [addr_w-1:0] a);
      xfer_cmd_t c;
      c.read = rd;
      c.lock = lk;
      c.size = sz;
      c.addr = a;
      return c;
   endfunction

   // leaves the strobe high so pushes can run back to back
   task automatic push_cmd(input xfer_cmd_t c);
      @(negedge clk);
      while (cmd_full)
      begin
         cmd_push = 1'b0;
         full_waits++;
         @(negedge clk);
      end
      cmd      = c;
      cmd_push = 1'b1;
      exp_q.push_back(model_xfer(c));
   endtask

   task automatic stop_push();
      @(negedge clk);
      cmd_push = 1'b0;
   endtask

   task automatic compare_result(input xfer_result_t got, input xfer_result_t exp);
      stat_e gs;
      stat_e es;
      gs = got.status;
      es = exp.status;
      if (got !== exp)
      begin
         $display("ERR %0t result: got %s rdata %h, expected %s rdata %h",
                  $time, gs.name(), got.rdata, es.name(), exp.rdata);
         err_cnt++;
      end
   endtask

   task automatic compare_stat(input stat_e got, input stat_e exp);
      if (got !== exp)
      begin
         $display("ERR %0t result.status: got %s, expected %s", $time, got.name(), exp.name());
         err_cnt++;
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s: got %b, expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic collect_results();
      int           waited;
      xfer_result_t got;
      xfer_result_t exp;
      waited = 0;
      while ((got_q.size() < exp_q.size()) && (waited < result_wait))
      begin
         @(posedge clk);
         waited++;
      end
      if (got_q.size() < exp_q.size())
      begin
         $display("%0t: only %0d of %0d results arrived", $time, got_q.size(), exp_q.size());
         err_cnt++;
      end
      repeat (settle) @(posedge clk); // catch duplicates
      if (got_q.size() > exp_q.size())
      begin
         $display("%0t: %0d results for %0d commands", $time, got_q.size(), exp_q.size());
         err_cnt++;
      end
      while ((got_q.size() > 0) && (exp_q.size() > 0))
      begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         if (exp.status == STAT_ABORT)
            compare_stat(got.status, exp.status);
         else
            compare_result(got, exp);
      end
      got_q.delete();
      exp_q.delete();
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_cnt == errs_before)
         $display("%s: pass", name);
      else
      begin
         $display("%s: fail, %0d error(s)", name, err_cnt - errs_before);
         fail_tests++;
      end
   endtask

   task automatic test_fast();
      int                e0;
      logic [addr_w-1:0] a;
      e0 = err_cnt;
      repeat (3)
      begin
         a = rand_addr(REG_FAST);
         push_cmd(mk_cmd(1'b0, 1'b0, OPC_WORD, a));
         push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, a));
         stop_push();
         collect_results();
      end
      report_test("fast write and read-back", e0);
   endtask

   task automatic test_wait_half();
      int                e0;
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] b;
      e0 = err_cnt;
      a = rand_addr(REG_WAIT);
      b = a;
      b[15:6] = ~a[15:6]; // same word with a new low half
      push_cmd(mk_cmd(1'b0, 1'b0, OPC_WORD, a));
      push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, a));
      push_cmd(mk_cmd(1'b0, 1'b0, OPC_HALF, b));
      push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, a));
      stop_push();
      collect_results();
      report_test("wait and half-word", e0);
   endtask

   task automatic test_retract();
      int                e0;
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] c;
      e0 = err_cnt;
      a = rand_addr(REG_RETRACT);
      c = rand_addr(REG_FAST);
      c[$clog2(mem_words)-1:0] = a[$clog2(mem_words)-1:0];
      push_cmd(mk_cmd(1'b0, 1'b0, OPC_WORD, a));
      push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, a));
      push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, c));
      stop_push();
      collect_results();
      report_test("retract", e0);
   endtask

   task automatic test_fault();
      int                e0;
      logic [addr_w-1:0] a;
      e0 = err_cnt;
      a = rand_addr(REG_FAULT);
      a[27] = 1'b0; // error
      push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, a));
      stop_push();
      collect_results();
      a = rand_addr(REG_FAULT);
      a[27] = 1'b1; // hang until timeout
      push_cmd(mk_cmd(1'b0, 1'b0, OPC_WORD, a));
      stop_push();
      collect_results();
      a = rand_addr(REG_FAST);
      push_cmd(mk_cmd(1'b0, 1'b0, OPC_WORD, a));
      push_cmd(mk_cmd(1'b1, 1'b0, OPC_WORD, a));
      stop_push();
      collect_results();
      report_test("error and timeout", e0);
   endtask

   task automatic test_locked();
      int                e0;
      int                w0;
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] b;
      e0 = err_cnt;
      w0 = full_waits;
      a = rand_addr(REG_FAST);
      b = rand_addr(REG_FAST);
      push_cmd(mk_cmd(1'b0, 1'b1, OPC_WORD, a));
      push_cmd(mk_cmd(1'b1, 1'b1, OPC_WORD, a));
      push_cmd(mk_cmd(1'b0, 1'b1, OPC_WORD, b));
      push_cmd(mk_cmd(1'b1, 1'b1, OPC_WORD, b));
      stop_push();
      compare_bit("cmd_full", cmd_full, 1'b1);
      if (full_waits != w0)
      begin
         $display("%0t: queue went full before the fourth push", $time);
         err_cnt++;
      end
      collect_results();
      report_test("locked overlap and queue full", e0);
   endtask

   initial
   begin
      seed       = 32'h1f46_6fd7;
      rst_n      = 1'b0;
      cmd_push   = 1'b0;
      cmd        = '0;
      err_cnt    = 0;
      fail_tests = 0;
      full_waits = 0;
      foreach (model_mem[i])
         model_mem[i] = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(posedge clk);

      test_fast();
      test_wait_half();
      test_retract();
      test_fault();
      test_locked();

      $display("tests %0d, failed tests %0d, errors %0d", n_tests, fail_tests, err_cnt);
      if (err_cnt == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule
